// File: bench/control_unit_checker.sv
`timescale 1ns/1ps

module control_unit_checker
(
	input  logic clock,
	input  logic cpucycle_rst,
	input  logic inst_ready,
	input  isa_pkg::uop_t seq_uop,
	input  logic seq_valid,
	input  bus_pkg::ctrl_word_t ctrl,
	input  logic ctrl_valid,
	input  logic ctrl_ready
);
	import isa_pkg::*;

	int fail_count = 0;							// Read by the testbench at the end
	logic steps_left;							// BL or SWAP still has steps to issue

	assign steps_left = seq_valid && ((seq_uop.op == BL && seq_uop.step == 2'd0)
		|| (seq_uop.op == SWAP && seq_uop.step != 2'd2));

	reset_clears : assert property (@(posedge clock) cpucycle_rst |=> !ctrl_valid && inst_ready)
	else
	begin
		$error("Control word valid or instruction input blocked during reset");
		fail_count++;
	end

	held_stable : assert property (@(posedge clock) disable iff (cpucycle_rst)
		ctrl_valid && !ctrl_ready |=> ctrl_valid && $stable(ctrl))
	else
	begin
		$error("Held control word changed or was dropped under back-pressure");
		fail_count++;
	end

	steps_block : assert property (@(posedge clock) disable iff (cpucycle_rst)
		steps_left |-> !inst_ready)
	else
	begin
		$error("New instruction accepted while a BL or SWAP had steps left");
		fail_count++;
	end

endmodule

// File: bench/control_unit_tb.sv
`timescale 1ns/1ps

module control_unit_tb;
	import isa_pkg::*;
	import bus_pkg::*;

	localparam int NUM_INST    = 80;						// Upper bound on instructions sent
	localparam int MAX_CYCLES  = NUM_INST * 3 * 2 * 4 + 80;	// Steps, back-pressure, slack
	localparam int DRAIN_LIMIT = 100;						// Cycles to wait for words at test end

	logic clock;
	logic cpucycle_rst;
	inst_t inst;
	logic inst_valid;
	logic inst_ready;
	logic [FLAG_W-1:0] flags;
	ctrl_word_t ctrl;
	logic ctrl_valid;
	logic ctrl_ready;

	integer seed;
	integer bp_seed;										// Separate stream for ctrl_ready
	int cycles = 0;
	int test_errs = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	bit bp_on;												// Random ctrl_ready when set
	string test_name = "reset";
	ctrl_word_t exp_q[$];									// Expected words in issue order
	bit win_active;											// Reference CEX window
	bit win_result;
	int win_t;
	int win_f;

	control_unit u_control_unit (.*);

	bind control_unit control_unit_checker u_control_unit_checker (.*);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles in test %s", cycles, test_name);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic int rand_below(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic inst_t rand_inst(opcode_e op);
		inst_t i;
		i.op = op;
		i.dst = 3'(rand_below(8));
		i.src = 3'(rand_below(8));
		i.rc = 1'(rand_below(2));
		i.wb = 1'(rand_below(2));
		i.cond = cond_e'(4'(rand_below(15)));				// EQ..AL only
		i.t_cnt = 3'(rand_below(4));
		i.f_cnt = 3'(rand_below(4));
		i.flag_mask = 5'(rand_below(32));
		return i;
	endfunction

	function automatic opcode_e alu_or_mov();
		return (rand_below(4) == 0) ? MOV : opcode_e'(7'(int'(ADD) + rand_below(12)));
	endfunction

	function automatic bit cond_holds(cond_e code, logic [FLAG_W-1:0] f);
		bit c, z, n, v;
		c = f[FLAG_C];
		z = f[FLAG_Z];
		n = f[FLAG_N];
		v = f[FLAG_V];
		case (code)
			EQ: return z;
			NE: return !z;
			CS: return c;
			CC: return !c;
			MI: return n;
			PL: return !n;
			VS: return v;
			VC: return !v;
			HI: return c && !z;
			LS: return !c || z;
			GE: return n == v;
			LT: return n != v;
			GT: return !z && (n == v);
			LE: return z || (n != v);
			default: return 1'b1;							// AL
		endcase
	endfunction

	function automatic ctrl_word_t expect_word(inst_t i, int step);
		ctrl_word_t w;
		w = '0;
		w.data_src = REG_FILE;								// Register moves are the common case
		w.data_dst = REG_FILE;
		case (i.op)
			BL:
			begin
				w.data_src = (step == 0) ? REG_FILE : ALU;
				w.dbus_rnum_src = (step == 0) ? REG_PC : 5'd0;
				w.dbus_rnum_dst = (step == 0) ? REG_LR : REG_PC;
				w.sxt_bit_num = (step == 0) ? 5'd13 : 5'd0;
				w.s_bus_sel = (step == 0);
				w.psw_update = (step == 0);
			end
			BEQ, BNE, BC, BNC, BN, BGE, BLT, BRA:
			begin
				w.data_src = NONE;							// PC plus offset stays in the ALU
				w.data_dst = NONE;
				w.alu_rnum_dst = REG_PC;
				w.s_bus_sel = 1'b1;
				w.sxt_bit_num = 5'd10;
			end
			MOV:
			begin
				w.dbus_rnum_src = 5'(i.src);
				w.dbus_rnum_dst = 5'(i.dst);
				w.word_byte = i.wb;
			end
			SWAP:
			begin
				w.dbus_rnum_src = (step == 0) ? 5'(i.src) : (step == 1) ? 5'(i.dst) : REG_TEMP;
				w.dbus_rnum_dst = (step == 0) ? REG_TEMP : (step == 1) ? 5'(i.src) : 5'(i.dst);
			end
			SETCC, CLRCC:
			begin
				w.data_src = NONE;
				w.data_dst = NONE;
				w.flag_set = (i.op == SETCC) ? i.flag_mask : 5'd0;
				w.flag_clr = (i.op == CLRCC) ? i.flag_mask : 5'd0;
			end
			default:										// ALU group
			begin
				w.data_src = ALU;
				w.alu_op = 6'(2 * (int'(i.op) - int'(ADD)) + int'(i.wb));
				w.alu_rnum_dst = 5'(i.dst);
				w.alu_rnum_src = 5'(i.src) + (i.rc ? 5'd8 : 5'd0);
				w.dbus_rnum_dst = 5'(i.dst);
				w.psw_update = 1'b1;
				w.word_byte = i.wb;
			end
		endcase
		return w;
	endfunction

	// Reference model step for one accepted instruction
	task automatic model_accept(inst_t i, logic [FLAG_W-1:0] f);
		bit run;
		int steps;
		if (i.op == CEX)
		begin
			win_active = 1'b1;
			win_result = cond_holds(i.cond, f);
			win_t = i.t_cnt;
			win_f = i.f_cnt;
		end
		else
		begin
			run = 1'b1;
			if (win_active)
			begin
				if (win_t > 0)
				begin
					run = win_result;
					win_t--;
				end
				else if (win_f > 0)
				begin
					run = !win_result;
					win_f--;
				end
				win_active = (win_t > 0) || (win_f > 0);
			end
			case (i.op)
				BEQ: run = run && cond_holds(EQ, f);
				BNE: run = run && cond_holds(NE, f);
				BC: run = run && cond_holds(CS, f);
				BNC: run = run && cond_holds(CC, f);
				BN: run = run && cond_holds(MI, f);
				BGE: run = run && cond_holds(GE, f);
				BLT: run = run && cond_holds(LT, f);
				default: run = run;						// BRA and the rest always go
			endcase
			steps = (i.op == BL) ? 2 : (i.op == SWAP) ? 3 : 1;
			for (int s = 0; run && s < steps; s++)
				exp_q.push_back(expect_word(i, s));
		end
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic send(inst_t i);
		logic [FLAG_W-1:0] f;
		f = 5'(rand_below(32));
		inst = i;
		flags = f;
		inst_valid = 1'b1;
		while (!inst_ready)
			@(negedge clock);
		model_accept(i, f);									// Transfer on the coming rising edge
		@(negedge clock);
		inst_valid = 1'b0;
	endtask

	task automatic end_test();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0 || ctrl_valid) && waited < DRAIN_LIMIT)
		begin
			@(negedge clock);
			waited++;
		end
		repeat (UOP_FIFO_DEPTH + 3)
			@(negedge clock);								// Let any extra word show up
		assert (exp_q.size() == 0)
		else
		begin
			$display("Test %s: %0d control words missing", test_name, exp_q.size());
			test_errs++;
			exp_q.delete();
		end
		$display("Test %s finished with %0d errors", test_name, test_errs);
		if (test_errs == 0)
			tests_passed++;
		else
			tests_failed++;
		test_errs = 0;
	endtask

	// Output side: pick ctrl_ready, then check the word that will transfer
	always @(negedge clock)
	begin : out_monitor
		logic rdy;
		ctrl_word_t exp_word;
		rdy = bp_on ? (($random(bp_seed) & 1) != 0) : 1'b1;
		ctrl_ready = rdy;
		if (!cpucycle_rst && ctrl_valid && rdy)
		begin
			assert (exp_q.size() != 0)
			else
			begin
				$display("Test %s: control word %h came out with none expected", test_name, ctrl);
				test_errs++;
			end
			if (exp_q.size() != 0)
			begin
				exp_word = exp_q.pop_front();
				assert (ctrl == exp_word)
				else
				begin
					$display("MISMATCH %s expected %h actual %h", test_name, exp_word, ctrl);
					test_errs++;
				end
			end
		end
	end

	initial
	begin : stimulus
		inst_t c;
		opcode_e op;
		seed = 32'h1d59_b964;
		bp_seed = seed ^ 32'h5a5a_5a5a;
		cpucycle_rst = 1'b1;
		inst = '0;
		inst_valid = 1'b0;
		flags = '0;
		ctrl_ready = 1'b1;
		bp_on = 1'b0;
		repeat (8)
			@(posedge clock);
		@(negedge clock);
		cpucycle_rst = 1'b0;

		test_name = "alu_mov";
		repeat (16)
			send(rand_inst(alu_or_mov()));
		end_test();

		test_name = "branches";
		for (int k = 0; k < 16; k++)
			send(rand_inst(opcode_e'(7'(int'(BEQ) + k % 8))));
		end_test();

		test_name = "cex_window";
		repeat (5)
		begin
			c = rand_inst(CEX);								// Next window opens right after
			send(c);
			repeat (int'(c.t_cnt) + int'(c.f_cnt))
				send(rand_inst(alu_or_mov()));
		end
		send(rand_inst(alu_or_mov()));						// Window closed, runs unconditionally
		end_test();

		test_name = "bl_swap";
		send(rand_inst(BL));
		send(rand_inst(SWAP));
		send(rand_inst(SWAP));
		send(rand_inst(BL));
		end_test();

		test_name = "setcc_clrcc";
		repeat (2)
		begin
			send(rand_inst(SETCC));
			send(rand_inst(CLRCC));
		end
		end_test();

		test_name = "backpressure";
		bp_on = 1'b1;
		repeat (20)
		begin
			case (rand_below(6))
				0: op = BL;
				1: op = SWAP;
				2: op = (rand_below(2) == 0) ? SETCC : CLRCC;
				3: op = opcode_e'(7'(int'(BEQ) + rand_below(8)));
				default: op = alu_or_mov();
			endcase
			send(rand_inst(op));
		end
		end_test();
		bp_on = 1'b0;

		$display("Tests passed: %0d, failed: %0d, assertion failures: %0d", tests_passed,
			tests_failed, u_control_unit.u_control_unit_checker.fail_count);
		if (tests_failed == 0 && u_control_unit.u_control_unit_checker.fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: files.f
verilog/isa_pkg.sv
verilog/bus_pkg.sv
verilog/cond_code_eval.sv
verilog/inst_sequencer.sv
verilog/uop_fifo.sv
verilog/bus_ctrl_decoder.sv
verilog/control_unit.sv
bench/control_unit_checker.sv
bench/control_unit_tb.sv

// File: verilog/bus_ctrl_decoder.sv
`timescale 1ns/1ps

module bus_ctrl_decoder
(
	input  logic clock,
	input  logic cpucycle_rst,
	input  isa_pkg::uop_t fifo_uop,
	input  logic fifo_valid,
	output logic fifo_ready,
	output bus_pkg::ctrl_word_t ctrl,
	output logic ctrl_valid,
	input  logic ctrl_ready
);
	import isa_pkg::*;
	import bus_pkg::*;

	ctrl_word_t ctrl_nxt;
	logic [4:0] alu_ofs;								// Offset of the op from ADD
	logic take;

	assign fifo_ready = ctrl_ready || !ctrl_valid;		// Slot free or being emptied
	assign take       = fifo_valid && fifo_ready;
	assign alu_ofs    = fifo_uop.op[4:0] - 5'(ADD);

	always_comb
	begin
		ctrl_nxt = '0;									// Unused fields stay zero
		case (fifo_uop.op)
			BL:
			begin
				if (fifo_uop.step == 2'd0)
				begin
					ctrl_nxt.data_src      = REG_FILE;		// Save return address
					ctrl_nxt.data_dst      = REG_FILE;
					ctrl_nxt.dbus_rnum_src = REG_PC;
					ctrl_nxt.dbus_rnum_dst = REG_LR;
					ctrl_nxt.sxt_bit_num   = 5'd13;
					ctrl_nxt.s_bus_sel     = 1'b1;
					ctrl_nxt.psw_update    = 1'b1;
				end
				else
				begin
					ctrl_nxt.data_src      = ALU;			// Target into PC
					ctrl_nxt.data_dst      = REG_FILE;
					ctrl_nxt.dbus_rnum_dst = REG_PC;
				end
			end
			BEQ, BNE, BC, BNC, BN, BGE, BLT, BRA:		// Only taken branches get here
			begin
				ctrl_nxt.alu_op       = 6'd0;				// Add offset to PC
				ctrl_nxt.alu_rnum_dst = REG_PC;
				ctrl_nxt.s_bus_sel    = 1'b1;
				ctrl_nxt.sxt_bit_num  = 5'd10;
			end
			ADD, ADDC, SUB, SUBC, DADD, CMP, XOR, AND, OR, BIT, BIC, BIS:
			begin
				ctrl_nxt.alu_op        = {alu_ofs, fifo_uop.wb};
				ctrl_nxt.alu_rnum_dst  = {2'b00, fifo_uop.dst};
				ctrl_nxt.alu_rnum_src  = {2'b00, fifo_uop.src}
					+ (fifo_uop.rc ? REG_CONST2 - 5'd2 : 5'd0);	// Bank starts two below const 2
				ctrl_nxt.dbus_rnum_dst = {2'b00, fifo_uop.dst};
				ctrl_nxt.data_src      = ALU;
				ctrl_nxt.data_dst      = REG_FILE;
				ctrl_nxt.psw_update    = 1'b1;
				ctrl_nxt.word_byte     = fifo_uop.wb;
			end
			MOV:
			begin
				ctrl_nxt.data_src      = REG_FILE;
				ctrl_nxt.data_dst      = REG_FILE;
				ctrl_nxt.dbus_rnum_src = {2'b00, fifo_uop.src};
				ctrl_nxt.dbus_rnum_dst = {2'b00, fifo_uop.dst};
				ctrl_nxt.word_byte     = fifo_uop.wb;
			end
			SWAP:
			begin
				ctrl_nxt.data_src = REG_FILE;
				ctrl_nxt.data_dst = REG_FILE;
				case (fifo_uop.step)
					2'd0:
					begin
						ctrl_nxt.dbus_rnum_src = {2'b00, fifo_uop.src};	// src to temp
						ctrl_nxt.dbus_rnum_dst = REG_TEMP;
					end
					2'd1:
					begin
						ctrl_nxt.dbus_rnum_src = {2'b00, fifo_uop.dst};	// dst to src
						ctrl_nxt.dbus_rnum_dst = {2'b00, fifo_uop.src};
					end
					default:
					begin
						ctrl_nxt.dbus_rnum_src = REG_TEMP;				// temp to dst
						ctrl_nxt.dbus_rnum_dst = {2'b00, fifo_uop.dst};
					end
				endcase
			end
			SETCC: ctrl_nxt.flag_set = fifo_uop.flag_mask;
			CLRCC: ctrl_nxt.flag_clr = fifo_uop.flag_mask;
			default: ctrl_nxt = '0;						// CEX never reaches the decoder
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			ctrl_valid <= 1'b0;
		else if (take)
			ctrl_valid <= 1'b1;
		else if (ctrl_ready)
			ctrl_valid <= 1'b0;							// Word consumed, nothing new
	end

	always_ff @(posedge clock)
	begin
		if (take)
			ctrl <= ctrl_nxt;							// Stable while ctrl_ready is low
	end

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

	typedef enum logic [1:0]
	{
		NONE     = 2'd0,					// No transfer on the data bus
		REG_FILE = 2'd1,
		ALU      = 2'd2,
		SXT      = 2'd3						// Sign extender output
	} bus_unit_e;

	localparam logic [4:0] REG_LR     = 5'd5;	// Link register
	localparam logic [4:0] REG_PC     = 5'd7;
	localparam logic [4:0] REG_CONST2 = 5'd10;	// Constant 2 in the constant bank
	localparam logic [4:0] REG_TEMP   = 5'd16;	// Hidden scratch register for SWAP

	localparam int UOP_FIFO_DEPTH = 4;		// Micro-steps buffered before the decoder

	typedef struct packed
	{
		bus_unit_e   data_src;				// Data bus driver
		bus_unit_e   data_dst;				// Data bus receiver
		logic [4:0]  dbus_rnum_src;
		logic [4:0]  dbus_rnum_dst;
		logic [4:0]  alu_rnum_src;
		logic [4:0]  alu_rnum_dst;
		logic [5:0]  alu_op;				// Op offset times two, plus byte bit
		logic        psw_update;			// ALU writes the flags
		logic        s_bus_sel;				// 1 = sign extender feeds the S bus
		logic [4:0]  sxt_bit_num;			// Sign bit position of the offset
		logic        word_byte;
		logic [4:0]  flag_set;
		logic [4:0]  flag_clr;
	} ctrl_word_t;

endpackage

// File: verilog/cond_code_eval.sv
`timescale 1ns/1ps

module cond_code_eval
(
	input  isa_pkg::cond_e cond,
	input  logic [isa_pkg::FLAG_W-1:0] flags,
	output logic result
);
	import isa_pkg::*;

	always_comb
	begin
		case (cond)
			EQ: result = flags[FLAG_Z];
			NE: result = !flags[FLAG_Z];
			CS: result = flags[FLAG_C];							// Also HS
			CC: result = !flags[FLAG_C];						// Also LO
			MI: result = flags[FLAG_N];
			PL: result = !flags[FLAG_N];
			VS: result = flags[FLAG_V];
			VC: result = !flags[FLAG_V];
			HI: result = flags[FLAG_C] && !flags[FLAG_Z];
			LS: result = !flags[FLAG_C] || flags[FLAG_Z];
			GE: result = (flags[FLAG_N] == flags[FLAG_V]);
			LT: result = (flags[FLAG_N] != flags[FLAG_V]);
			GT: result = !flags[FLAG_Z] && (flags[FLAG_N] == flags[FLAG_V]);
			LE: result = flags[FLAG_Z] || (flags[FLAG_N] != flags[FLAG_V]);
			AL: result = 1'b1;
			default: result = 1'b0;								// Code 15 never holds
		endcase
	end

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit
(
	input  logic clock,
	input  logic cpucycle_rst,
	input  isa_pkg::inst_t inst,
	input  logic inst_valid,
	output logic inst_ready,
	input  logic [isa_pkg::FLAG_W-1:0] flags,
	output bus_pkg::ctrl_word_t ctrl,
	output logic ctrl_valid,
	input  logic ctrl_ready
);
	import isa_pkg::*;

	uop_t seq_uop, fifo_uop;							// Micro-steps before and after the buffer
	logic seq_valid, seq_ready;
	logic fifo_valid, fifo_ready;

	inst_sequencer u_inst_sequencer
	(
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.inst         (inst),
		.inst_valid   (inst_valid),
		.inst_ready   (inst_ready),
		.flags        (flags),
		.seq_uop      (seq_uop),
		.seq_valid    (seq_valid),
		.seq_ready    (seq_ready)
	);

	uop_fifo u_uop_fifo
	(
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.seq_uop      (seq_uop),
		.seq_valid    (seq_valid),
		.seq_ready    (seq_ready),
		.fifo_uop     (fifo_uop),
		.fifo_valid   (fifo_valid),
		.fifo_ready   (fifo_ready)
	);

	bus_ctrl_decoder u_bus_ctrl_decoder
	(
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.fifo_uop     (fifo_uop),
		.fifo_valid   (fifo_valid),
		.fifo_ready   (fifo_ready),
		.ctrl         (ctrl),
		.ctrl_valid   (ctrl_valid),
		.ctrl_ready   (ctrl_ready)
	);

endmodule

// File: verilog/inst_sequencer.sv
`timescale 1ns/1ps

module inst_sequencer
(
	input  logic clock,
	input  logic cpucycle_rst,
	input  isa_pkg::inst_t inst,
	input  logic inst_valid,
	output logic inst_ready,
	input  logic [isa_pkg::FLAG_W-1:0] flags,
	output isa_pkg::uop_t seq_uop,
	output logic seq_valid,
	input  logic seq_ready
);
	import isa_pkg::*;

	logic cex_active;							// Window open
	logic cex_result;							// Condition captured by CEX
	logic [2:0] cex_t, cex_f;					// Remaining true/false counts
	logic [2:0] cex_t_nxt, cex_f_nxt;
	logic [1:0] step_last;						// Index of the final step of seq_uop
	cond_e cond_sel;
	logic cond_true;
	logic accept, advance, final_step;
	logic is_cex, is_branch;
	logic hit_t, hit_f, win_exec, issue;

	assign final_step = (seq_uop.step == step_last);
	assign advance    = seq_valid && seq_ready;
	assign inst_ready = !seq_valid || (seq_ready && final_step);	// Idle or last step leaving
	assign accept     = inst_valid && inst_ready;

	assign is_cex    = (inst.op == CEX);
	assign is_branch = inst.op inside {[BEQ:BRA]};

	// Branch opcode to condition code
	always_comb
	begin
		case (inst.op)
			BEQ, BNE, BC, BNC, BN: cond_sel = cond_e'(inst.op[3:0] - 4'd1);	// EQ..MI
			BGE, BLT: cond_sel = cond_e'(inst.op[3:0] + 4'd4);				// GE, LT
			BRA: cond_sel = AL;
			default: cond_sel = inst.cond;									// CEX condition
		endcase
	end

	cond_code_eval u_cond_code_eval
	(
		.cond   (cond_sel),
		.flags  (flags),
		.result (cond_true)
	);

	assign hit_t    = cex_active && (cex_t != 3'd0);				// True half of window
	assign hit_f    = cex_active && !hit_t && (cex_f != 3'd0);		// Then the false half
	assign win_exec = hit_t ? cex_result : (hit_f ? !cex_result : 1'b1);
	assign issue    = accept && !is_cex && win_exec && (!is_branch || cond_true);

	assign cex_t_nxt = cex_t - {2'b00, hit_t};
	assign cex_f_nxt = cex_f - {2'b00, hit_f};

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			seq_valid  <= 1'b0;
			cex_active <= 1'b0;
			cex_result <= 1'b0;
			cex_t      <= 3'd0;
			cex_f      <= 3'd0;
		end
		else
		begin
			if (issue)
				seq_valid <= 1'b1;								// Step 0 of the new instruction
			else if (advance && final_step)
				seq_valid <= 1'b0;								// Nothing follows
			if (accept && is_cex)
			begin
				cex_active <= 1'b1;								// A new window replaces the old one
				cex_result <= cond_true;
				cex_t      <= inst.t_cnt;
				cex_f      <= inst.f_cnt;
			end
			else if (accept && cex_active)
			begin
				cex_t      <= cex_t_nxt;
				cex_f      <= cex_f_nxt;
				cex_active <= (cex_t_nxt != 3'd0) || (cex_f_nxt != 3'd0);	// Close when spent
			end
		end
	end

	// Step payload and step counter
	always_ff @(posedge clock)
	begin
		if (issue)
		begin
			seq_uop <= '{op: inst.op, step: 2'd0, dst: inst.dst, src: inst.src,
				rc: inst.rc, wb: inst.wb, flag_mask: inst.flag_mask};
			case (inst.op)
				BL: step_last <= 2'd1;
				SWAP: step_last <= 2'd2;
				default: step_last <= 2'd0;
			endcase
		end
		else if (advance && !final_step)
			seq_uop.step <= seq_uop.step + 2'd1;			// Held while seq_ready is low
	end

endmodule

// File: verilog/isa_pkg.sv
package isa_pkg;

	typedef enum logic [6:0]
	{
		BL    = 7'd0,						// Branch and link, two steps
		BEQ   = 7'd1,						// Conditional branches
		BNE   = 7'd2,
		BC    = 7'd3,
		BNC   = 7'd4,
		BN    = 7'd5,
		BGE   = 7'd6,
		BLT   = 7'd7,
		BRA   = 7'd8,						// Unconditional
		ADD   = 7'd9,						// Two-operand ALU group starts here
		ADDC  = 7'd10,
		SUB   = 7'd11,
		SUBC  = 7'd12,
		DADD  = 7'd13,
		CMP   = 7'd14,
		XOR   = 7'd15,
		AND   = 7'd16,
		OR    = 7'd17,
		BIT   = 7'd18,
		BIC   = 7'd19,
		BIS   = 7'd20,						// Last ALU op
		MOV   = 7'd21,
		SWAP  = 7'd22,						// Three steps through the temp register
		SETCC = 7'd30,
		CLRCC = 7'd31,
		CEX   = 7'd32						// Opens a conditional-execute window
	} opcode_e;

	typedef enum logic [3:0]
	{
		EQ = 4'd0, NE = 4'd1, CS = 4'd2, CC = 4'd3,
		MI = 4'd4, PL = 4'd5, VS = 4'd6, VC = 4'd7,
		HI = 4'd8, LS = 4'd9, GE = 4'd10, LT = 4'd11,
		GT = 4'd12, LE = 4'd13, AL = 4'd14
	} cond_e;

	localparam int FLAG_C = 0;				// Carry
	localparam int FLAG_Z = 1;				// Zero
	localparam int FLAG_N = 2;				// Negative
	localparam int FLAG_V = 4;				// Overflow
	localparam int FLAG_W = 5;				// Width of the flag field in the PSW

	typedef struct packed
	{
		opcode_e     op;
		logic [2:0]  dst;					// Destination register
		logic [2:0]  src;					// Source register or constant index
		logic        rc;					// Src selects the constant bank
		logic        wb;					// 1 = byte
		cond_e       cond;					// CEX condition
		logic [2:0]  t_cnt;					// CEX true count
		logic [2:0]  f_cnt;					// CEX false count
		logic [FLAG_W-1:0] flag_mask;		// SETCC/CLRCC bits
	} inst_t;

	typedef struct packed
	{
		opcode_e     op;
		logic [1:0]  step;					// Position within a multi-step instruction
		logic [2:0]  dst;
		logic [2:0]  src;
		logic        rc;
		logic        wb;
		logic [FLAG_W-1:0] flag_mask;
	} uop_t;

endpackage

// File: verilog/uop_fifo.sv
`timescale 1ns/1ps

module uop_fifo
(
	input  logic clock,
	input  logic cpucycle_rst,
	input  isa_pkg::uop_t seq_uop,
	input  logic seq_valid,
	output logic seq_ready,
	output isa_pkg::uop_t fifo_uop,
	output logic fifo_valid,
	input  logic fifo_ready
);
	import isa_pkg::*;
	import bus_pkg::*;

	uop_t mem [UOP_FIFO_DEPTH];
	logic [$clog2(UOP_FIFO_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(UOP_FIFO_DEPTH+1)-1:0] count;		// Occupancy, 0..depth
	logic wr_en, rd_en;

	assign seq_ready  = (count != UOP_FIFO_DEPTH);		// Full drops ready
	assign fifo_valid = (count != '0);
	assign fifo_uop   = mem[rd_ptr];
	assign wr_en      = seq_valid && seq_ready;
	assign rd_en      = fifo_valid && fifo_ready;

	always_ff @(posedge clock)
	begin
		if (wr_en)
			mem[wr_ptr] <= seq_uop;
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= (wr_ptr == UOP_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;	// Wrap
			if (rd_en)
				rd_ptr <= (rd_ptr == UOP_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;				// Both or neither
			endcase
		end
	end

endmodule
